/* src/miner_uart_pkg.sv */
package miner_uart_pkg;

    // block header framing
    localparam int header_bytes = 80;
    localparam int header_bits  = header_bytes * 8;

    localparam int nonce_bytes = 4; // nonce goes out msb first

    // shared by receiver and transmitter
    typedef enum logic [1:0] {
        idle,
        start_bit,
        data_bits,
        stop_bit
    } uart_state_t;

    // nonce transmit sequencer
    typedef enum logic [1:0] {
        wait_request, // idle, watching for a send edge
        load_byte,    // present next byte once tx is free
        wait_busy,    // tx has not picked up the byte yet
        wait_done     // frame on the line
    } sender_state_t;

endpackage

/* src/uart_rx.sv */
module uart_rx
    import miner_uart_pkg::*;
#(
    parameter int clks_per_bit = 868
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       rxd,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    localparam int count_w = $clog2(clks_per_bit);
    localparam logic [count_w-1:0] half_count = count_w'(clks_per_bit / 2 - 1);
    localparam logic [count_w-1:0] last_count = count_w'(clks_per_bit - 1);

    uart_state_t        state;
    logic [count_w-1:0] count;
    logic [2:0]         bit_index;
    logic               rxd_meta;
    logic               rxd_sync;
    logic               frame_error; // set on a low stop bit, held until the line idles
    logic [7:0]         rx_shift;

    always_ff @(posedge clock) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= idle;
            count       <= '0;
            bit_index   <= '0;
            frame_error <= 1'b0;
            rx_valid    <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                idle: begin
                    count <= '0;
                    if (frame_error) begin
                        if (rxd_sync) frame_error <= 1'b0; // line back to mark
                    end else if (!rxd_sync) begin
                        state <= start_bit;
                    end
                end
                start_bit: begin
                    if (count == half_count) begin
                        count     <= '0;
                        bit_index <= '0;
                        state     <= rxd_sync ? idle : data_bits; // glitch rejects
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                data_bits: begin
                    if (count == last_count) begin
                        count     <= '0;
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == 3'd7) state <= stop_bit;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                stop_bit: begin
                    if (count == last_count) begin
                        count <= '0;
                        state <= idle;
                        if (rxd_sync) rx_valid <= 1'b1;
                        else frame_error <= 1'b1;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == data_bits && count == last_count) begin
            rx_shift <= {rxd_sync, rx_shift[7:1]}; // lsb arrives first
        end
    end

    assign rx_data = rx_shift;

endmodule

/* src/uart_tx.sv */
module uart_tx
    import miner_uart_pkg::*;
#(
    parameter int clks_per_bit = 868
) (
    input  logic       clock,
    input  logic       reset,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       txd,
    output logic       tx_busy
);

    localparam int count_w = $clog2(clks_per_bit);
    localparam logic [count_w-1:0] last_count = count_w'(clks_per_bit - 1);

    uart_state_t        state;
    logic [count_w-1:0] count;
    logic [2:0]         bit_index;
    logic [7:0]         tx_shift;

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= idle;
            count     <= '0;
            bit_index <= '0;
            txd       <= 1'b1;
            tx_busy   <= 1'b0;
        end else begin
            if (state == idle) begin
                count <= '0;
                if (tx_start) begin
                    state   <= start_bit;
                    txd     <= 1'b0;
                    tx_busy <= 1'b1;
                end
            end else if (count != last_count) begin
                count <= count + 1'b1;
            end else begin
                count <= '0; // bit time over
                case (state)
                    start_bit: begin
                        state     <= data_bits;
                        bit_index <= '0;
                        txd       <= tx_shift[0];
                    end
                    data_bits: begin
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == 3'd7) begin
                            state <= stop_bit;
                            txd   <= 1'b1;
                        end else begin
                            txd <= tx_shift[1];
                        end
                    end
                    default: begin
                        state   <= idle; // end of stop bit
                        tx_busy <= 1'b0;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (state == idle && tx_start) begin
            tx_shift <= tx_data;
        end else if (state == data_bits && count == last_count) begin
            tx_shift <= {1'b0, tx_shift[7:1]};
        end
    end

endmodule

/* src/header_collector.sv */
module header_collector
    import miner_uart_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic [7:0]             rx_data,
    input  logic                   rx_valid,
    output logic [header_bits-1:0] header,
    output logic                   header_ready
);

    localparam int count_w = $clog2(header_bytes);
    localparam logic [count_w-1:0] last_byte = count_w'(header_bytes - 1);

    logic [count_w-1:0] byte_count;

    always_ff @(posedge clock) begin
        if (reset) begin
            byte_count   <= '0;
            header_ready <= 1'b0;
        end else begin
            header_ready <= 1'b0;
            if (rx_valid) begin
                if (byte_count == last_byte) begin
                    byte_count   <= '0;
                    header_ready <= 1'b1;
                end else begin
                    byte_count <= byte_count + 1'b1;
                end
            end
        end
    end

    // earlier bytes move up, first byte ends in the top slot
    always_ff @(posedge clock) begin
        if (rx_valid) begin
            header <= {header[header_bits-9:0], rx_data};
        end
    end

endmodule

/* src/nonce_sender.sv */
module nonce_sender
    import miner_uart_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic [31:0] nonce,
    input  logic        nonce_we,
    input  logic        send,
    input  logic        tx_busy,
    output logic [7:0]  tx_data,
    output logic        tx_start,
    output logic [31:0] nonce_value
);

    localparam int index_w = $clog2(nonce_bytes);
    localparam logic [index_w-1:0] last_index = index_w'(nonce_bytes - 1);

    sender_state_t      state;
    logic               send_prev;
    logic               send_rise;
    logic [index_w-1:0] byte_index;
    logic [31:0]        send_copy; // shifted copy, display keeps nonce_value

    assign send_rise = send & ~send_prev;
    assign tx_data   = send_copy[31:24];

    always_ff @(posedge clock) begin
        if (reset) begin
            nonce_value <= '0;
            send_prev   <= 1'b0;
        end else begin
            send_prev <= send;
            if (nonce_we) nonce_value <= nonce;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= wait_request;
            byte_index <= '0;
            tx_start   <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            case (state)
                wait_request: begin
                    byte_index <= '0;
                    if (send_rise) state <= load_byte;
                end
                load_byte: begin
                    if (!tx_busy) begin
                        tx_start <= 1'b1;
                        state    <= wait_busy;
                    end
                end
                wait_busy: begin
                    if (tx_busy) state <= wait_done; // tx took the byte
                end
                default: begin
                    if (!tx_busy) begin
                        byte_index <= byte_index + 1'b1;
                        state      <= (byte_index == last_index) ? wait_request : load_byte;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == wait_request && send_rise) begin
            send_copy <= nonce_value;
        end else if (state == wait_done && !tx_busy) begin
            send_copy <= {send_copy[23:0], 8'h00};
        end
    end

endmodule

/* src/segment_display.sv */
module segment_display #(
    parameter int scan_clks = 1024
) (
    input  logic        clock,
    input  logic        reset,
    input  logic [31:0] value,
    output logic [7:0]  ca,
    output logic [7:0]  an
);

    localparam int scan_w = $clog2(scan_clks);
    localparam logic [scan_w-1:0] last_scan = scan_w'(scan_clks - 1);

    logic [scan_w-1:0] scan_count;
    logic [2:0]        digit;
    logic [3:0]        nibble;
    logic [6:0]        segments; // g..a, active low

    assign nibble = value[{digit, 2'b00} +: 4];

    always_comb begin
        case (nibble)
            4'h0: segments = 7'h40;
            4'h1: segments = 7'h79;
            4'h2: segments = 7'h24;
            4'h3: segments = 7'h30;
            4'h4: segments = 7'h19;
            4'h5: segments = 7'h12;
            4'h6: segments = 7'h02;
            4'h7: segments = 7'h78;
            4'h8: segments = 7'h00;
            4'h9: segments = 7'h10;
            4'ha: segments = 7'h08;
            4'hb: segments = 7'h03;
            4'hc: segments = 7'h46;
            4'hd: segments = 7'h21;
            4'he: segments = 7'h06;
            default: segments = 7'h0e;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            scan_count <= '0;
            digit      <= '0;
            ca         <= 8'hff;
            an         <= 8'hfe;
        end else begin
            if (scan_count == last_scan) begin
                scan_count <= '0;
                digit      <= digit + 1'b1;
            end else begin
                scan_count <= scan_count + 1'b1;
            end
            ca <= {1'b1, segments}; // dp off
            an <= ~(8'b0000_0001 << digit);
        end
    end

endmodule

/* src/miner_uart_top.sv */
module miner_uart_top
    import miner_uart_pkg::*;
#(
    parameter int clks_per_bit = 868,
    parameter int scan_clks    = 1024
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        rxd,
    input  logic [31:0] nonce,
    input  logic        nonce_we,
    input  logic        send,
    input  logic        display_select,
    output logic        txd,
    output logic        header_ready,
    output logic [7:0]  ca,
    output logic [7:0]  an
);

    logic [7:0]             rx_data;
    logic                   rx_valid;
    logic [header_bits-1:0] header;
    logic [7:0]             tx_data;
    logic                   tx_start;
    logic                   tx_busy;
    logic [31:0]            nonce_value;
    logic [31:0]            display_word;

    // first four header bytes, or the loaded nonce
    assign display_word = display_select ? header[header_bits-1 -: 32] : nonce_value;

    uart_rx #(
        .clks_per_bit(clks_per_bit)
    ) u_uart_rx (
        .clock   (clock),
        .reset   (reset),
        .rxd     (rxd),
        .rx_data (rx_data),
        .rx_valid(rx_valid)
    );

    header_collector u_header_collector (
        .clock       (clock),
        .reset       (reset),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .header      (header),
        .header_ready(header_ready)
    );

    nonce_sender u_nonce_sender (
        .clock      (clock),
        .reset      (reset),
        .nonce      (nonce),
        .nonce_we   (nonce_we),
        .send       (send),
        .tx_busy    (tx_busy),
        .tx_data    (tx_data),
        .tx_start   (tx_start),
        .nonce_value(nonce_value)
    );

    uart_tx #(
        .clks_per_bit(clks_per_bit)
    ) u_uart_tx (
        .clock   (clock),
        .reset   (reset),
        .tx_data (tx_data),
        .tx_start(tx_start),
        .txd     (txd),
        .tx_busy (tx_busy)
    );

    segment_display #(
        .scan_clks(scan_clks)
    ) u_segment_display (
        .clock(clock),
        .reset(reset),
        .value(display_word),
        .ca   (ca),
        .an   (an)
    );

endmodule

/* dv/miner_uart_properties.sv */
module miner_uart_properties (
    input logic       clock,
    input logic       reset,
    input logic       txd,
    input logic       header_ready,
    input logic [7:0] ca,
    input logic [7:0] an
);
    timeunit 1ns;
    timeprecision 100ps;

    // line must idle at mark once reset releases
    txd_high_after_reset: assert property (@(posedge clock) reset |=> txd)
        else $error("txd low in the cycle after reset");

    header_ready_single: assert property (
        @(posedge clock) disable iff (reset) header_ready |=> !header_ready
    ) else $error("header_ready high for two cycles in a row");

    one_digit_lit: assert property (@(posedge clock) disable iff (reset) $onehot(~an))
        else $error("an does not have exactly one zero bit");

    dp_off: assert property (@(posedge clock) disable iff (reset) ca[7])
        else $error("decimal point segment driven on");

endmodule

bind miner_uart_top miner_uart_properties u_properties (
    .clock       (clock),
    .reset       (reset),
    .txd         (txd),
    .header_ready(header_ready),
    .ca          (ca),
    .an          (an)
);

/* dv/miner_uart_tb.sv */
module miner_uart_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clks_per_bit = 8;
    localparam int scan_clks    = 4;
    localparam int header_len   = 80;
    localparam int wait_limit   = 4000; // cycles allowed for any single wait
    localparam int frame_clks   = 10 * clks_per_bit;

    logic        clock;
    logic        reset;
    logic        rxd;
    logic [31:0] nonce;
    logic        nonce_we;
    logic        send;
    logic        display_select;
    logic        txd;
    logic        header_ready;
    logic [7:0]  ca;
    logic [7:0]  an;

    integer      seed;
    int          ready_pulses = 0;

    miner_uart_top #(
        .clks_per_bit(clks_per_bit),
        .scan_clks   (scan_clks)
    ) u_dut (
        .clock         (clock),
        .reset         (reset),
        .rxd           (rxd),
        .nonce         (nonce),
        .nonce_we      (nonce_we),
        .send          (send),
        .display_select(display_select),
        .txd           (txd),
        .header_ready  (header_ready),
        .ca            (ca),
        .an            (an)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(negedge clock) begin
        if (!reset && header_ready === 1'b1) ready_pulses <= ready_pulses + 1;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("** Error: %s expected 0x%0h, got 0x%0h at %0t", name, expected, actual,
                 $time);
        $display("Simulation FAILED");
        $fatal(1, "value mismatch on %s", name);
    endtask

    task automatic report_failure(input string what);
        $display("%s at %0t", what, $time);
        $display("Simulation FAILED");
        $fatal(1, "%s", what);
    endtask

    // lit segments gfedcba of the standard hex table
    function automatic logic [6:0] segment_pattern(input logic [3:0] digit_value);
        logic [6:0] lit;
        case (digit_value)
            4'h0: lit = 7'h3f;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5b;
            4'h3: lit = 7'h4f;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6d;
            4'h6: lit = 7'h7d;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7f;
            4'h9: lit = 7'h6f;
            4'ha: lit = 7'h77;
            4'hb: lit = 7'h7c;
            4'hc: lit = 7'h39;
            4'hd: lit = 7'h5e;
            4'he: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit; // pins are active low
    endfunction

    // one host frame on rxd from falling edge to falling edge
    task automatic send_frame(input logic [7:0] data, input logic stop_level);
        rxd = 1'b0;
        repeat (clks_per_bit) @(negedge clock);
        for (int i = 0; i < 8; i++) begin
            rxd = data[i];
            repeat (clks_per_bit) @(negedge clock);
        end
        rxd = stop_level;
        repeat (clks_per_bit) @(negedge clock);
        rxd = 1'b1;
        repeat (2 * clks_per_bit) @(negedge clock); // idle gap
    endtask

    task automatic receive_frame(output logic [7:0] data);
        int waited;
        waited = 0;
        data = '0;
        @(negedge clock);
        while (txd !== 1'b0 && waited < wait_limit) begin
            waited++;
            @(negedge clock);
        end
        if (txd !== 1'b0) report_failure("timeout waiting for a start bit on txd");
        repeat (clks_per_bit / 2 - 1) @(negedge clock); // to mid start bit
        assert (txd === 1'b0) else report_mismatch("txd start bit", 32'h0, 32'(txd));
        for (int i = 0; i < 8; i++) begin
            repeat (clks_per_bit) @(negedge clock);
            data[i] = txd;
        end
        repeat (clks_per_bit) @(negedge clock);
        assert (txd === 1'b1) else report_mismatch("txd stop bit", 32'h1, 32'(txd));
    endtask

    task automatic expect_nonce_frames(input logic [31:0] word);
        logic [7:0] got;
        for (int b = 3; b >= 0; b--) begin
            receive_frame(got);
            assert (got === word[8*b +: 8])
                else report_mismatch("txd byte", 32'(word[8*b +: 8]), 32'(got));
        end
    endtask

    task automatic check_txd_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            assert (txd === 1'b1) else report_mismatch("txd", 32'h1, 32'(txd));
        end
    endtask

    task automatic load_nonce(input logic [31:0] word);
        nonce    = word;
        nonce_we = 1'b1;
        @(negedge clock);
        nonce_we = 1'b0;
        @(negedge clock);
    endtask

    // 80 good bytes with a bad stop bit frame ahead of byte bad_at when bad_at >= 0
    task automatic send_header(input int bad_at, output logic [31:0] first_word);
        logic [7:0] data;
        int         start_pulses;
        int         waited;
        start_pulses = ready_pulses;
        first_word   = '0;
        for (int n = 0; n < header_len; n++) begin
            if (n == bad_at) begin
                data = 8'($random(seed));
                send_frame(data, 1'b0);
            end
            data = 8'($random(seed));
            if (n < 4) first_word[31 - 8*n -: 8] = data;
            if (n == header_len - 1) begin
                assert (ready_pulses == start_pulses)
                    else report_mismatch("header_ready pulses", 32'(start_pulses),
                                         32'(ready_pulses));
            end
            send_frame(data, 1'b1);
        end
        waited = 0;
        while (ready_pulses == start_pulses && waited < wait_limit) begin
            waited++;
            @(negedge clock);
        end
        if (ready_pulses == start_pulses) report_failure("timeout waiting for header_ready");
        repeat (4 * clks_per_bit) @(negedge clock);
        assert (ready_pulses == start_pulses + 1)
            else report_mismatch("header_ready pulses", 32'(start_pulses + 1),
                                 32'(ready_pulses));
    endtask

    task automatic check_display(input logic [31:0] word);
        int         waited;
        logic [7:0] want_an;
        logic [7:0] want_ca;
        repeat (2) @(negedge clock); // let ca follow a new word
        for (int k = 0; k < 8; k++) begin
            want_an = ~(8'h01 << k);
            want_ca = {1'b1, segment_pattern(word[4*k +: 4])};
            waited  = 0;
            while (an !== want_an && waited < wait_limit) begin
                waited++;
                @(negedge clock);
            end
            if (an !== want_an) report_failure("timeout waiting for the display scan");
            assert (ca === want_ca) else report_mismatch("ca", 32'(want_ca), 32'(ca));
        end
    endtask

    initial begin
        logic [31:0] nonce_word;
        logic [31:0] header_word;
        seed           = 32'h8c53_ce48;
        reset          = 1'b1;
        rxd            = 1'b1;
        nonce          = '0;
        nonce_we       = 1'b0;
        send           = 1'b0;
        display_select = 1'b0;
        repeat (4) @(negedge clock);
        reset = 1'b0;

        check_txd_idle(50); // quiet line after reset
        assert (ready_pulses == 0)
            else report_mismatch("header_ready pulses", 32'h0, 32'(ready_pulses));

        nonce_word = 32'($random(seed));
        load_nonce(nonce_word);
        send = 1'b1;
        @(negedge clock);
        send = 1'b0;
        expect_nonce_frames(nonce_word);
        check_txd_idle(3 * frame_clks);

        // held request with a second edge mid transmission
        send = 1'b1;
        fork
            expect_nonce_frames(nonce_word);
            begin
                repeat (20) @(negedge clock);
                send = 1'b0;
                @(negedge clock);
                send = 1'b1;
            end
        join
        check_txd_idle(3 * frame_clks);
        send = 1'b0;
        @(negedge clock);
        send = 1'b1;
        expect_nonce_frames(nonce_word);
        send = 1'b0;
        check_txd_idle(3 * frame_clks);

        display_select = 1'b1;
        send_header(-1, header_word);
        check_display(header_word);

        display_select = 1'b0;
        check_display(nonce_word);

        display_select = 1'b1;
        send_header(30, header_word); // framing error among the bytes
        check_display(header_word);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* miner_uart.f */
src/miner_uart_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/header_collector.sv
src/nonce_sender.sv
src/segment_display.sv
src/miner_uart_top.sv
dv/miner_uart_properties.sv
dv/miner_uart_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module miner_uart_tb -f miner_uart.f
	./obj_dir/Vminer_uart_tb 2>&1 | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then echo "test failed"; exit 1; fi
	@grep -q "Simulation PASSED" sim.log || { echo "test did not complete"; exit 1; }

clean:
	rm -rf obj_dir sim.log
